// ==== dbg_cpu_module.f ====
src/dbg_cpu_pkg.sv
src/dbg_crc32.sv
src/dbg_status_reg.sv
src/dbg_spr_biu.sv
src/dbg_burst_datapath.sv
src/dbg_burst_fsm.sv
src/dbg_cpu_module.sv
testbench/dbg_cpu_module_sva.sv
testbench/dbg_cpu_module_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= dbg_cpu_module_tb
FILELIST  ?= dbg_cpu_module.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output and log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || echo "tests failed" >> $(LOG)
	@cat $(LOG)
	@if grep -q "tests failed" $(LOG); then exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== testbench/dbg_cpu_module_tb.sv ====
////////////////////////////////////////////////////////////
// Testbench for the CPU debug module
// TAP data register driver and TDO sampling
// SPR memory model with random acknowledge delay
// Reference CRC-32 and burst read/write checks
////////////////////////////////////////////////////////////
module dbg_cpu_module_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import dbg_cpu_pkg::*;

  localparam int NUM_ITER    = 4;
  localparam int MAX_WORDS   = 8;
  localparam int POLL_MAX    = 20;
  localparam int BURST_CYC   = 4 + 1 + POLL_MAX + 32 * MAX_WORDS + 32 + 4;
  localparam int STATUS_CYC  = 4 + 1 + 32 + 4;
  localparam int ITER_CYC    = 2 * STATUS_CYC + 3 * BURST_CYC;
  localparam int TIMEOUT_CYC = 8 + NUM_ITER * ITER_CYC + BURST_CYC + STATUS_CYC + 300;

  logic        tck_i;
  logic        trstn_i;
  logic        tdi_i;
  logic        capture_dr_i;
  logic        shift_dr_i;
  logic        update_dr_i;
  logic [52:0] data_register_i;
  logic        module_select_i;
  logic        module_tdo_o;
  logic        top_inhibit_o;
  logic [15:0] cpu_addr_o;
  logic [31:0] cpu_data_o;
  logic [31:0] cpu_data_i;
  logic        cpu_stb_o;
  logic        cpu_we_o;
  logic        cpu_ack_i;
  logic        cpu_stall_o;
  logic        cpu_bp_i;

  logic        dr_load;           // Parallel load of the TAP register
  logic [52:0] dr_val;
  logic [31:0] mem [0:65535];     // SPR space
  int          seed = 32'h80f80783;
  int          errors;
  int          cycles;
  int unsigned ack_wait;

  dbg_cpu_module dut (.*);

  bind dbg_cpu_module dbg_cpu_module_sva u_sva (
    .tck_i(tck_i), .trstn_i(trstn_i), .cpu_stb_o(cpu_stb_o), .cpu_ack_i(cpu_ack_i),
    .cpu_addr_o(cpu_addr_o), .cpu_we_o(cpu_we_o), .update_dr_i(update_dr_i),
    .top_inhibit_o(top_inhibit_o)
  );

  initial
  begin
    tck_i = 1'b0;
    forever #5 tck_i = ~tck_i;
  end

  // TAP data register shifting right with tdi on top
  always @(posedge tck_i)
  begin
    if (dr_load)
      data_register_i <= dr_val;
    else if (shift_dr_i)
      data_register_i <= {tdi_i, data_register_i[52:1]};
  end

  always @(posedge tck_i)
  begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYC)
    begin
      $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYC);
      $display("tests failed");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////
  // SPR memory acking after 0 to 4 cycles
  initial
  begin
    cpu_ack_i  = 1'b0;
    cpu_data_i = '0;
    for (int i = 0; i < 65536; i++)
      mem[i] = {i[15:0] ^ 16'ha5c3, ~i[15:0]};  // Unique per address
    forever
    begin
      @(posedge tck_i);
      if (cpu_stb_o && trstn_i)
      begin
        ack_wait = $unsigned($random(seed)) % 5;
        repeat (ack_wait) @(posedge tck_i);
        if (cpu_we_o)
          mem[cpu_addr_o] = cpu_data_o;
        else
          cpu_data_i <= mem[cpu_addr_o];
        cpu_ack_i <= 1'b1;
        @(posedge tck_i);
        cpu_ack_i <= 1'b0;
      end
    end
  end

  // Reflected CRC-32 step over one bit
  function automatic logic [31:0] crc_step(input logic [31:0] c, input logic b);
    return {1'b0, c[31:1]} ^ ((c[0] ^ b) ? 32'hedb88320 : 32'h0);
  endfunction

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp)
    else
    begin
      errors++;
      $display("Error: %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic drive_cycle(input logic cap, input logic sh, input logic upd, input logic b);
    @(posedge tck_i);
    dr_load      <= 1'b0;
    capture_dr_i <= cap;
    shift_dr_i   <= sh;
    update_dr_i  <= upd;
    tdi_i        <= b;
  endtask

  task automatic shift_bit(input logic b, output logic o);
    drive_cycle(1'b0, 1'b1, 1'b0, b);
    @(negedge tck_i);
    o = module_tdo_o;  // TDO for this shift cycle
  endtask

  // Load the register and pulse update before one idle cycle
  task automatic send_cmd(input logic [52:0] v);
    @(posedge tck_i);
    dr_load      <= 1'b1;
    dr_val       <= v;
    capture_dr_i <= 1'b0;
    shift_dr_i   <= 1'b0;
    drive_cycle(1'b0, 1'b0, 1'b1, 1'b0);
    drive_cycle(1'b0, 1'b0, 1'b0, 1'b0);
  endtask

  ////////////////////////////////////////////////////////////
  // Test sequences
  task automatic status_roundtrip(input logic s);
    logic [31:0] rd;
    logic        o;
    send_cmd({1'b0, CMD_IREG_WR, s, 47'b0});
    @(negedge tck_i);
    check_value("cpu_stall_o", {31'b0, cpu_stall_o}, {31'b0, s});
    drive_cycle(1'b1, 1'b0, 1'b0, 1'b0);  // Capture stall snapshot
    for (int b = 0; b < 32; b++)
    begin
      shift_bit(1'b0, o);
      rd[b] = o;
    end
    drive_cycle(1'b0, 1'b0, 1'b0, 1'b0);
    check_value("module_tdo_o status word", rd, {31'b0, s});
  endtask

  task automatic write_burst(input int n, input logic bad);
    logic [31:0] words [MAX_WORDS];
    logic [31:0] addr;
    logic [31:0] crc;
    logic [31:0] crc_tx;
    logic [15:0] a;
    int          flip;
    logic        o;
    addr = $random(seed);
    crc  = 32'hffffffff;
    for (int k = 0; k < n; k++)
    begin
      words[k] = $random(seed);
      for (int b = 0; b < 32; b++)
        crc = crc_step(crc, words[k][b]);
    end
    flip   = $unsigned($random(seed)) % 32;
    crc_tx = bad ? (crc ^ (32'h1 << flip)) : crc;
    send_cmd({1'b0, CMD_BWRITE32, addr, 16'(n)});
    drive_cycle(1'b1, 1'b0, 1'b0, 1'b0);
    shift_bit(1'b1, o);                   // Start bit
    for (int k = 0; k < n; k++)
      for (int b = 0; b < 32; b++)
        shift_bit(words[k][b], o);
    for (int b = 0; b < 32; b++)
      shift_bit(crc_tx[b], o);
    drive_cycle(1'b0, 1'b0, 1'b0, 1'b0);
    @(negedge tck_i);
    check_value("module_tdo_o crc match", {31'b0, module_tdo_o}, {31'b0, ~bad});
    drive_cycle(1'b0, 1'b0, 1'b1, 1'b0);
    drive_cycle(1'b0, 1'b0, 1'b0, 1'b0);
    for (int k = 0; k < n; k++)
    begin
      a = addr[15:0] + 16'(k);            // Consecutive SPRs
      check_value("mem write word", mem[a], words[k]);
    end
  endtask

  // Starts a read and polls ready until data follows
  task automatic start_read(input int n, input logic [31:0] addr, output logic ready);
    logic o;
    send_cmd({1'b0, CMD_BREAD32, addr, 16'(n)});
    drive_cycle(1'b1, 1'b0, 1'b0, 1'b0);
    ready = 1'b0;
    for (int p = 0; p < POLL_MAX && !ready; p++)
    begin
      shift_bit(1'b0, o);
      ready = o;
    end
    if (!ready)
    begin
      errors++;
      $display("Read ready bit never came up after %0d polls", POLL_MAX);
    end
  endtask

  task automatic read_burst(input int n);
    logic [31:0] addr;
    logic [31:0] word;
    logic [31:0] crc;
    logic [31:0] rd_crc;
    logic        ready;
    logic        o;
    addr = $random(seed);
    crc  = 32'hffffffff;
    start_read(n, addr, ready);
    if (ready)
    begin
      for (int k = 0; k < n; k++)
      begin
        for (int b = 0; b < 32; b++)
        begin
          shift_bit(1'b0, o);
          word[b] = o;
          crc     = crc_step(crc, o);
        end
        check_value("module_tdo_o read word", word, mem[addr[15:0] + 16'(k)]);
      end
      for (int b = 0; b < 32; b++)
      begin
        shift_bit(1'b0, o);
        rd_crc[b] = o;
      end
      check_value("module_tdo_o read crc", rd_crc, crc);
    end
    drive_cycle(1'b0, 1'b0, 1'b1, 1'b0);
    drive_cycle(1'b0, 1'b0, 1'b0, 1'b0);
  endtask

  initial
  begin
    logic o;
    logic ready;
    trstn_i         = 1'b0;
    tdi_i           = 1'b0;
    capture_dr_i    = 1'b0;
    shift_dr_i      = 1'b0;
    update_dr_i     = 1'b0;
    module_select_i = 1'b1;
    cpu_bp_i        = 1'b0;
    dr_load         = 1'b0;
    dr_val          = '0;
    data_register_i = '0;
    errors          = 0;
    cycles          = 0;
    repeat (8) @(posedge tck_i);
    trstn_i <= 1'b1;
    @(negedge tck_i);
    check_value("module_tdo_o", {31'b0, module_tdo_o}, 32'h0);
    check_value("top_inhibit_o", {31'b0, top_inhibit_o}, 32'h0);
    check_value("cpu_stb_o", {31'b0, cpu_stb_o}, 32'h0);
    check_value("cpu_stall_o", {31'b0, cpu_stall_o}, 32'h0);
    for (int it = 0; it < NUM_ITER; it++)
    begin
      status_roundtrip($random(seed) & 1);
      status_roundtrip(1'b0);
      @(posedge tck_i);
      cpu_bp_i <= 1'b1;                   // Breakpoint sets stall
      @(posedge tck_i);
      cpu_bp_i <= 1'b0;
      @(negedge tck_i);
      check_value("cpu_stall_o after bp", {31'b0, cpu_stall_o}, 32'h1);
      write_burst(1 + $unsigned($random(seed)) % MAX_WORDS, 1'b0);
      write_burst(1 + $unsigned($random(seed)) % MAX_WORDS, 1'b1);
      read_burst(1 + $unsigned($random(seed)) % MAX_WORDS);
    end
    // Early end of a read burst
    start_read(MAX_WORDS, $random(seed), ready);
    for (int b = 0; b < 40; b++)
      shift_bit(1'b0, o);
    drive_cycle(1'b0, 1'b0, 1'b1, 1'b0);
    drive_cycle(1'b0, 1'b0, 1'b0, 1'b0);
    @(negedge tck_i);
    assert (!top_inhibit_o)
    else
    begin
      errors++;
      $display("top_inhibit_o still high after an early update");
    end
    repeat (8) drive_cycle(1'b0, 1'b0, 1'b0, 1'b0);
    status_roundtrip($random(seed) & 1);
    $display("Errors: %0d", errors);
    if (errors == 0)
      $display("all tests passed");
    else
      $display("tests failed");
    $finish;
  end

endmodule

// ==== testbench/dbg_cpu_module_sva.sv ====
////////////////////////////////////////////////////////////
// Bound protocol assertions for the CPU debug module
// SPR strobe hold, write enable stability, inhibit release
////////////////////////////////////////////////////////////
module dbg_cpu_module_sva (
  input logic                   tck_i,
  input logic                   trstn_i,
  input logic                   cpu_stb_o,
  input logic                   cpu_ack_i,
  input dbg_cpu_pkg::spr_addr_t cpu_addr_o,
  input logic                   cpu_we_o,
  input logic                   update_dr_i,
  input logic                   top_inhibit_o
);
  timeunit 1ns;
  timeprecision 1ps;

  // Strobe and address held until acknowledge
  stb_hold: assert property (@(posedge tck_i) disable iff (!trstn_i)
    cpu_stb_o && !cpu_ack_i |=> cpu_stb_o && $stable(cpu_addr_o))
    else $error("SPR strobe dropped or address moved before acknowledge");

  we_stable: assert property (@(posedge tck_i) disable iff (!trstn_i)
    cpu_stb_o && !cpu_ack_i |=> $stable(cpu_we_o))
    else $error("SPR write enable changed during strobe");

  // FSM idle after update, so no inhibit
  inhibit_idle: assert property (@(posedge tck_i) disable iff (!trstn_i)
    update_dr_i |=> !top_inhibit_o)
    else $error("top_inhibit_o high in idle");

endmodule

// ==== src/dbg_cpu_module.sv ====
////////////////////////////////////////////////////////////
// CPU debug module top level
// Burst FSM, datapath, CRC, SPR bus unit and stall register
////////////////////////////////////////////////////////////
module dbg_cpu_module (
  input  logic                   tck_i,
  input  logic                   trstn_i,
  // TAP
  input  logic                   tdi_i,
  input  logic                   capture_dr_i,
  input  logic                   shift_dr_i,
  input  logic                   update_dr_i,
  input  dbg_cpu_pkg::dreg_t     data_register_i,
  input  logic                   module_select_i,
  output logic                   module_tdo_o,
  output logic                   top_inhibit_o,
  // SPR bus
  output dbg_cpu_pkg::spr_addr_t cpu_addr_o,
  output dbg_cpu_pkg::word_t     cpu_data_o,
  input  dbg_cpu_pkg::word_t     cpu_data_i,
  output logic                   cpu_stb_o,
  output logic                   cpu_we_o,
  input  logic                   cpu_ack_i,
  // Stall control
  output logic                   cpu_stall_o,
  input  logic                   cpu_bp_i
);
  import dbg_cpu_pkg::*;

  logic      addr_ld, addr_inc, op_ld, word_ld, word_dec, bit_rst, bit_inc;
  logic      out_ld, out_src_biu, out_shift, out_lsb, rd_op;
  logic      crc_clr, crc_en, crc_in_sel, crc_shift, crc_match, crc_serial;
  logic      biu_strobe, biu_rdy, status_we;
  logic      word_count_zero, decremented_zero, bit_count_max, bit_count_32;
  tdo_sel_t  tdo_sel;
  addr_cnt_t addr;
  word_t     crc;
  word_t     biu_rdata;

  dbg_burst_fsm u_fsm (
    .tck_i, .trstn_i, .module_select_i, .capture_dr_i, .shift_dr_i, .update_dr_i,
    .data_register_i, .biu_rdy_i(biu_rdy), .word_count_zero_i(word_count_zero),
    .decremented_zero_i(decremented_zero), .bit_count_max_i(bit_count_max),
    .bit_count_32_i(bit_count_32), .crc_i(crc), .addr_ld_o(addr_ld),
    .addr_inc_o(addr_inc), .op_ld_o(op_ld), .word_ld_o(word_ld), .word_dec_o(word_dec),
    .bit_rst_o(bit_rst), .bit_inc_o(bit_inc), .out_ld_o(out_ld),
    .out_src_biu_o(out_src_biu), .out_shift_o(out_shift), .tdo_sel_o(tdo_sel),
    .crc_clr_o(crc_clr), .crc_en_o(crc_en), .crc_in_sel_o(crc_in_sel),
    .crc_shift_o(crc_shift), .crc_match_o(crc_match), .biu_strobe_o(biu_strobe),
    .status_we_o(status_we), .top_inhibit_o
  );

  dbg_burst_datapath u_datapath (
    .tck_i, .trstn_i, .data_register_i, .addr_ld_i(addr_ld), .addr_inc_i(addr_inc),
    .op_ld_i(op_ld), .word_ld_i(word_ld), .word_dec_i(word_dec), .bit_rst_i(bit_rst),
    .bit_inc_i(bit_inc), .out_ld_i(out_ld), .out_src_biu_i(out_src_biu),
    .out_shift_i(out_shift), .tdo_sel_i(tdo_sel), .biu_data_i(biu_rdata),
    .stall_i(cpu_stall_o), .biu_rdy_i(biu_rdy), .crc_match_i(crc_match),
    .crc_serial_i(crc_serial), .addr_o(addr), .rd_op_o(rd_op), .out_lsb_o(out_lsb),
    .word_count_zero_o(word_count_zero), .decremented_zero_o(decremented_zero),
    .bit_count_max_o(bit_count_max), .bit_count_32_o(bit_count_32), .module_tdo_o
  );

  dbg_crc32 u_crc (
    .tck_i, .trstn_i, .clr_i(crc_clr), .en_i(crc_en), .shift_i(crc_shift),
    .in_sel_i(crc_in_sel), .tdi_i, .data_i(out_lsb), .crc_o(crc), .serial_o(crc_serial)
  );

  // Write word is tdi_i over the 31 bits already shifted in
  dbg_spr_biu u_biu (
    .tck_i, .trstn_i, .strobe_i(biu_strobe), .rd_wrn_i(rd_op), .addr_i(addr),
    .data_i({tdi_i, data_register_i[FLAG_BIT -: WORD_BITS_M1]}), .data_o(biu_rdata),
    .rdy_o(biu_rdy), .cpu_addr_o, .cpu_data_o, .cpu_data_i, .cpu_stb_o, .cpu_we_o,
    .cpu_ack_i
  );

  dbg_status_reg u_status (
    .tck_i, .trstn_i, .we_i(status_we), .stall_i(data_register_i[STALL_BIT]),
    .bp_i(cpu_bp_i), .stall_o(cpu_stall_o)
  );

endmodule

// ==== src/dbg_burst_fsm.sv ====
////////////////////////////////////////////////////////////
// Burst control FSM
// Command decode, read prefetch and hi-speed write strobes
// Datapath, CRC and BIU controls plus top_inhibit_o
////////////////////////////////////////////////////////////
module dbg_burst_fsm (
  input  logic                  tck_i,
  input  logic                  trstn_i,
  // TAP
  input  logic                  module_select_i,
  input  logic                  capture_dr_i,
  input  logic                  shift_dr_i,
  input  logic                  update_dr_i,
  input  dbg_cpu_pkg::dreg_t    data_register_i,
  // Status
  input  logic                  biu_rdy_i,
  input  logic                  word_count_zero_i,
  input  logic                  decremented_zero_i,
  input  logic                  bit_count_max_i,
  input  logic                  bit_count_32_i,
  input  dbg_cpu_pkg::word_t    crc_i,
  // Datapath controls
  output logic                  addr_ld_o,
  output logic                  addr_inc_o,
  output logic                  op_ld_o,
  output logic                  word_ld_o,
  output logic                  word_dec_o,
  output logic                  bit_rst_o,
  output logic                  bit_inc_o,
  output logic                  out_ld_o,
  output logic                  out_src_biu_o,
  output logic                  out_shift_o,
  output dbg_cpu_pkg::tdo_sel_t tdo_sel_o,
  // CRC controls
  output logic                  crc_clr_o,
  output logic                  crc_en_o,
  output logic                  crc_in_sel_o,  // 1 write data, 0 read data
  output logic                  crc_shift_o,
  output logic                  crc_match_o,
  output logic                  biu_strobe_o,
  output logic                  status_we_o,
  output logic                  top_inhibit_o
);
  import dbg_cpu_pkg::*;

  burst_state_t state_q;
  burst_state_t state_nxt;
  opcode_t      op_in;
  logic         cmd_valid;  // Update of a command addressed to us
  logic         burst_cmd;
  logic         ireg_wr;
  logic         rd_load;    // Load a read word into the output register

  assign op_in     = data_register_i[OP_MSB:OP_LSB];
  assign cmd_valid = module_select_i & ~data_register_i[FLAG_BIT] & update_dr_i;
  assign burst_cmd = (op_in == CMD_BWRITE32) | (op_in == CMD_BREAD32);
  assign ireg_wr   = (op_in == CMD_IREG_WR);

  // Received CRC sits in the top 32 bits of the data register
  assign crc_match_o = (data_register_i[FLAG_BIT -: 32] == crc_i);

  always_ff @(posedge tck_i or negedge trstn_i)
  begin
    if (!trstn_i)
      state_q <= ST_IDLE;
    else
      state_q <= state_nxt;
  end

  ////////////////////////////////////////////////////////////
  // Next state
  always_comb
  begin
    state_nxt = state_q;
    if (update_dr_i && state_q != ST_IDLE)
      state_nxt = ST_IDLE;  // Host ended the burst
    else
      case (state_q)
        ST_IDLE    : if (cmd_valid && burst_cmd)
                       state_nxt = op_in[OP_RD_BIT] ? ST_RBEGIN : ST_WREADY;
        ST_RBEGIN  : state_nxt = word_count_zero_i ? ST_IDLE : ST_RREADY;
        ST_RREADY  : if (module_select_i && capture_dr_i) state_nxt = ST_RSTATUS;
        ST_RSTATUS : if (biu_rdy_i) state_nxt = ST_RBURST;
        ST_RBURST  : if (bit_count_max_i && word_count_zero_i) state_nxt = ST_RCRC;
        ST_WREADY  :
          if (word_count_zero_i)
            state_nxt = ST_IDLE;  // Empty write burst
          else if (module_select_i && capture_dr_i)
            state_nxt = ST_WWAIT;
        ST_WWAIT   : if (module_select_i && shift_dr_i && data_register_i[FLAG_BIT])
                       state_nxt = ST_WBURST;  // Start bit seen
        ST_WBURST  : if (bit_count_max_i && word_count_zero_i) state_nxt = ST_WCRC;
        ST_WCRC    : if (bit_count_32_i) state_nxt = ST_WMATCH;
        ST_RCRC,
        ST_WMATCH  : state_nxt = state_q;  // Hold until update_dr_i
        default    : state_nxt = ST_IDLE;
      endcase
  end

  // Word boundary in a read, entering or staying in the data phase
  assign rd_load = (state_nxt == ST_RBURST) & ((state_q == ST_RSTATUS) | bit_count_max_i);

  ////////////////////////////////////////////////////////////
  // Controls
  always_comb
  begin
    addr_ld_o     = 1'b0;
    addr_inc_o    = 1'b0;
    op_ld_o       = 1'b0;
    word_ld_o     = 1'b0;
    word_dec_o    = 1'b0;
    bit_rst_o     = 1'b0;
    bit_inc_o     = 1'b0;
    out_ld_o      = 1'b0;
    out_src_biu_o = 1'b0;
    out_shift_o   = 1'b0;
    tdo_sel_o     = SEL_DATA_OUT;
    crc_clr_o     = 1'b0;
    crc_en_o      = 1'b0;
    crc_in_sel_o  = 1'b0;
    crc_shift_o   = 1'b0;
    biu_strobe_o  = 1'b0;
    status_we_o   = 1'b0;
    top_inhibit_o = 1'b0;
    case (state_q)
      ST_IDLE:
      begin
        out_shift_o = module_select_i & shift_dr_i;    // Status register readout
        out_ld_o    = module_select_i & capture_dr_i;  // Snapshot of the stall bit
        status_we_o = cmd_valid & ireg_wr;
        if (state_nxt != ST_IDLE)
        begin
          addr_ld_o = 1'b1;
          op_ld_o   = 1'b1;
          word_ld_o = 1'b1;
          bit_rst_o = 1'b1;
          crc_clr_o = 1'b1;
        end
      end
      ST_RBEGIN:
      begin
        biu_strobe_o = ~word_count_zero_i;  // Fetch the first word
        addr_inc_o   = ~word_count_zero_i;
      end
      ST_RSTATUS:
      begin
        tdo_sel_o     = SEL_BIU_READY;
        top_inhibit_o = 1'b1;
      end
      ST_RBURST:
      begin
        out_shift_o   = 1'b1;
        bit_inc_o     = 1'b1;
        crc_en_o      = 1'b1;  // CRC over outgoing bits
        top_inhibit_o = 1'b1;
      end
      ST_RCRC:
      begin
        tdo_sel_o     = SEL_CRC_OUT;
        crc_shift_o   = 1'b1;
        top_inhibit_o = 1'b1;
      end
      ST_WWAIT:
      begin
        top_inhibit_o = 1'b1;
        if (state_nxt == ST_WBURST)
        begin
          bit_inc_o    = 1'b1;
          word_dec_o   = 1'b1;  // Pre-decrement
          crc_en_o     = 1'b1;  // tdi_i already holds the first data bit
          crc_in_sel_o = 1'b1;
        end
      end
      ST_WBURST:
      begin
        bit_inc_o     = 1'b1;
        crc_en_o      = 1'b1;
        crc_in_sel_o  = 1'b1;
        top_inhibit_o = 1'b1;
        if (bit_count_max_i && !update_dr_i)
        begin
          bit_rst_o    = 1'b1;
          biu_strobe_o = 1'b1;  // No status stop between words
          addr_inc_o   = 1'b1;
          word_dec_o   = 1'b1;
        end
      end
      ST_WCRC:
      begin
        bit_inc_o     = 1'b1;
        top_inhibit_o = 1'b1;
        if (bit_count_32_i)
          tdo_sel_o = SEL_CRC_MATCH;
      end
      ST_WMATCH:
      begin
        tdo_sel_o     = SEL_CRC_MATCH;
        top_inhibit_o = 1'b1;
      end
      default: ;
    endcase
    if (rd_load)
    begin
      out_ld_o      = 1'b1;
      out_src_biu_o = 1'b1;
      bit_rst_o     = 1'b1;
      word_dec_o    = 1'b1;
      if (!decremented_zero_i && !word_count_zero_i)
      begin
        biu_strobe_o = 1'b1;  // Prefetch the next word
        addr_inc_o   = 1'b1;
      end
    end
  end

endmodule

// ==== src/dbg_burst_datapath.sv ====
////////////////////////////////////////////////////////////
// Burst datapath
// Address, word and bit counters, opcode latch
// Output shift register and TDO multiplexer
////////////////////////////////////////////////////////////
module dbg_burst_datapath (
  input  logic                   tck_i,
  input  logic                   trstn_i,
  input  dbg_cpu_pkg::dreg_t     data_register_i,
  // Controls from the FSM
  input  logic                   addr_ld_i,
  input  logic                   addr_inc_i,
  input  logic                   op_ld_i,
  input  logic                   word_ld_i,
  input  logic                   word_dec_i,
  input  logic                   bit_rst_i,
  input  logic                   bit_inc_i,
  input  logic                   out_ld_i,
  input  logic                   out_src_biu_i,  // 1 BIU data, 0 status register
  input  logic                   out_shift_i,
  input  dbg_cpu_pkg::tdo_sel_t  tdo_sel_i,
  // Data and status sources
  input  dbg_cpu_pkg::word_t     biu_data_i,
  input  logic                   stall_i,
  input  logic                   biu_rdy_i,
  input  logic                   crc_match_i,
  input  logic                   crc_serial_i,
  // Results
  output dbg_cpu_pkg::addr_cnt_t addr_o,
  output logic                   rd_op_o,
  output logic                   out_lsb_o,
  output logic                   word_count_zero_o,
  output logic                   decremented_zero_o,
  output logic                   bit_count_max_o,
  output logic                   bit_count_32_o,
  output logic                   module_tdo_o
);
  import dbg_cpu_pkg::*;

  word_cnt_t word_cnt;
  bit_cnt_t  bit_cnt;
  opcode_t   op_q;
  word_t     out_sreg;  // Shifts toward bit 0

  ////////////////////////////////////////////////////////////
  // Counters and opcode latch
  always_ff @(posedge tck_i or negedge trstn_i)
  begin
    if (!trstn_i)
    begin
      addr_o   <= '0;
      word_cnt <= '0;
      bit_cnt  <= '0;
      op_q     <= '0;
    end
    else
    begin
      if (addr_ld_i)
        addr_o <= data_register_i[ADDR_MSB:ADDR_LSB];
      else if (addr_inc_i)
        addr_o <= addr_o + 1'b1;       // One SPR per word
      if (word_ld_i)
        word_cnt <= data_register_i[COUNT_MSB:COUNT_LSB];
      else if (word_dec_i)
        word_cnt <= word_cnt - 1'b1;
      if (bit_rst_i)
        bit_cnt <= '0;                  // Reset wins over increment
      else if (bit_inc_i)
        bit_cnt <= bit_cnt + 1'b1;
      if (op_ld_i)
        op_q <= data_register_i[OP_MSB:OP_LSB];
    end
  end

  assign rd_op_o            = op_q[OP_RD_BIT];
  assign word_count_zero_o  = (word_cnt == '0);
  assign decremented_zero_o = (word_cnt == word_cnt_t'(1));  // Next count would be zero
  assign bit_count_max_o    = (bit_cnt == bit_cnt_t'(WORD_BITS_M1));
  assign bit_count_32_o     = (bit_cnt == bit_cnt_t'(32));   // CRC fully shifted in

  ////////////////////////////////////////////////////////////
  // Output shift register, load beats shift
  always_ff @(posedge tck_i or negedge trstn_i)
  begin
    if (!trstn_i)
      out_sreg <= '0;
    else if (out_ld_i)
      out_sreg <= out_src_biu_i ? biu_data_i : {{WORD_BITS_M1{1'b0}}, stall_i};
    else if (out_shift_i)
      out_sreg <= {1'b0, out_sreg[WORD_BITS_M1:1]};
  end

  assign out_lsb_o = out_sreg[0];

  always_comb
  begin
    case (tdo_sel_i)
      SEL_BIU_READY : module_tdo_o = biu_rdy_i;     // Read ready bit
      SEL_DATA_OUT  : module_tdo_o = out_sreg[0];
      SEL_CRC_MATCH : module_tdo_o = crc_match_i;
      default       : module_tdo_o = crc_serial_i;
    endcase
  end

endmodule

// ==== src/dbg_spr_biu.sv ====
////////////////////////////////////////////////////////////
// SPR bus interface unit
// Latches one access on strobe
// Runs the strobe/acknowledge handshake on tck_i
////////////////////////////////////////////////////////////
module dbg_spr_biu (
  input  logic                   tck_i,
  input  logic                   trstn_i,
  // Debug side
  input  logic                   strobe_i,    // Start an access
  input  logic                   rd_wrn_i,    // 1 read, 0 write
  input  dbg_cpu_pkg::addr_cnt_t addr_i,
  input  dbg_cpu_pkg::word_t     data_i,      // Write data
  output dbg_cpu_pkg::word_t     data_o,      // Last read data
  output logic                   rdy_o,
  // SPR bus
  output dbg_cpu_pkg::spr_addr_t cpu_addr_o,
  output dbg_cpu_pkg::word_t     cpu_data_o,
  input  dbg_cpu_pkg::word_t     cpu_data_i,
  output logic                   cpu_stb_o,
  output logic                   cpu_we_o,
  input  logic                   cpu_ack_i
);
  import dbg_cpu_pkg::*;

  typedef enum logic {BIU_IDLE, BIU_BUSY} biu_state_t;

  biu_state_t state_q;
  logic       start;
  logic       done;

  assign start = (state_q == BIU_IDLE) & strobe_i;
  assign done  = (state_q == BIU_BUSY) & cpu_ack_i;

  ////////////////////////////////////////////////////////////
  // Handshake state
  always_ff @(posedge tck_i or negedge trstn_i)
  begin
    if (!trstn_i)
    begin
      state_q  <= BIU_IDLE;
      cpu_we_o <= 1'b0;
    end
    else if (start)
    begin
      state_q  <= BIU_BUSY;
      cpu_we_o <= ~rd_wrn_i;
    end
    else if (done)
      state_q <= BIU_IDLE;  // Strobe drops on the edge after ack
  end

  // Access payload, stable through the strobe
  always_ff @(posedge tck_i)
  begin
    if (start)
    begin
      cpu_addr_o <= spr_addr_t'(addr_i);  // SPRs are word addressed, low bits only
      cpu_data_o <= data_i;
    end
    if (done && !cpu_we_o)
      data_o <= cpu_data_i;  // Held until the next read completes
  end

  assign cpu_stb_o = (state_q == BIU_BUSY);
  assign rdy_o     = (state_q == BIU_IDLE);

endmodule

// ==== src/dbg_status_reg.sv ====
////////////////////////////////////////////////////////////
// CPU stall status register
// Loaded by an internal register write
// Set by a breakpoint from the core
////////////////////////////////////////////////////////////
module dbg_status_reg (
  input  logic tck_i,
  input  logic trstn_i,
  input  logic we_i,     // Status write from the data register
  input  logic stall_i,  // Stall value to write
  input  logic bp_i,     // Breakpoint hit
  output logic stall_o
);

  // Breakpoint wins over a write that clears the stall
  always_ff @(posedge tck_i or negedge trstn_i)
  begin
    if (!trstn_i)
      stall_o <= 1'b0;
    else if (bp_i)
      stall_o <= 1'b1;
    else if (we_i)
      stall_o <= stall_i;
  end

endmodule

// ==== src/dbg_crc32.sv ====
////////////////////////////////////////////////////////////
// Bit-serial CRC-32, LSB first
// Input select between write data and read data
// Register doubles as its own output shift register
////////////////////////////////////////////////////////////
module dbg_crc32 (
  input  logic               tck_i,
  input  logic               trstn_i,
  input  logic               clr_i,     // Load start value
  input  logic               en_i,      // Fold one bit
  input  logic               shift_i,   // Shift toward bit 0
  input  logic               in_sel_i,  // 1 picks write data on tdi_i
  input  logic               tdi_i,
  input  logic               data_i,    // Read data bit
  output dbg_cpu_pkg::word_t crc_o,
  output logic               serial_o
);
  import dbg_cpu_pkg::*;

  logic bit_in;
  logic fb;

  assign bit_in = in_sel_i ? tdi_i : data_i;
  assign fb     = crc_o[0] ^ bit_in;  // Feedback term

  always_ff @(posedge tck_i or negedge trstn_i)
  begin
    if (!trstn_i)
      crc_o <= CRC_INIT;
    else if (clr_i)
      crc_o <= CRC_INIT;
    else if (en_i)
      crc_o <= {1'b0, crc_o[WORD_BITS_M1:1]} ^ (fb ? CRC_POLY : '0);
    else if (shift_i)
      crc_o <= {1'b0, crc_o[WORD_BITS_M1:1]};  // Zero fill
  end

  assign serial_o = crc_o[0];

endmodule

// ==== src/dbg_cpu_pkg.sv ====
////////////////////////////////////////////////////////////
// CPU debug module shared definitions
// Data register field positions and command opcodes
// CRC-32 constants and width typedefs
// Burst FSM states and TDO source encodings
////////////////////////////////////////////////////////////
package dbg_cpu_pkg;

  ////////////////////////////////////////////////////////////
  // TAP data register layout
  localparam int DATAREG_LEN  = 53;
  localparam int FLAG_BIT     = 52;  // 0 marks a module command, 1 is a write start bit
  localparam int OP_MSB       = 51;
  localparam int OP_LSB       = 48;
  localparam int ADDR_MSB     = 47;
  localparam int ADDR_LSB     = 16;
  localparam int COUNT_MSB    = 15;
  localparam int COUNT_LSB    = 0;
  localparam int STALL_BIT    = 47;  // Stall value in a status write
  localparam int OP_RD_BIT    = 2;   // Set in read opcodes
  localparam int WORD_BITS_M1 = 31;  // Word length minus one

  typedef logic [DATAREG_LEN-1:0]         dreg_t;
  typedef logic [OP_MSB-OP_LSB:0]         opcode_t;
  typedef logic [WORD_BITS_M1:0]          word_t;
  typedef logic [15:0]                    spr_addr_t;
  typedef logic [ADDR_MSB-ADDR_LSB:0]     addr_cnt_t;
  typedef logic [COUNT_MSB-COUNT_LSB:0]   word_cnt_t;
  typedef logic [5:0]                     bit_cnt_t;

  // Commands
  localparam opcode_t CMD_BWRITE32 = 4'h3;
  localparam opcode_t CMD_BREAD32  = 4'h7;
  localparam opcode_t CMD_IREG_WR  = 4'h9;

  // Reflected CRC-32, no final inversion
  localparam word_t CRC_POLY = 32'hedb8_8320;
  localparam word_t CRC_INIT = 32'hffff_ffff;

  typedef enum logic [3:0] {
    ST_IDLE, ST_RBEGIN, ST_RREADY, ST_RSTATUS, ST_RBURST, ST_RCRC,
    ST_WREADY, ST_WWAIT, ST_WBURST, ST_WCRC, ST_WMATCH
  } burst_state_t;

  typedef enum logic [1:0] {
    SEL_BIU_READY, SEL_DATA_OUT, SEL_CRC_MATCH, SEL_CRC_OUT
  } tdo_sel_t;

endpackage
